// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= eeprom_tb
SIM_DIR   ?= obj_dir
FILELIST  ?= project.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(SIM_DIR)

# the run passes only if the pass line shows up in the output
run: compile
	@out=$$(./$(SIM_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(SIM_DIR)

// ==== project.f ====
+incdir+source
source/eeprom_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_access_fsm.sv
source/eeprom_controller.sv
testbench/eeprom_model.sv
testbench/eeprom_tb.sv

// ==== source/eeprom_access_fsm.sv ====
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_access_fsm
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       wr,
    input  logic       rd,
    input  host_req_t  req,
    output logic       busy,
    output logic       ack,
    output logic [7:0] rdata,
    output logic       nack_seen,
    output logic       cmd_valid,
    output bus_cmd_t   cmd,
    input  logic       eng_busy,
    input  logic       op_done,
    input  bus_rsp_t   rsp
);

    access_state_t state;
    host_req_t     req_q;
    logic          rd_q;     // current access is a read
    logic          issued;   // command of this state already sent

    assign busy = (state != IDLE);

    // one command per bus state, sent once the engine is free
    assign cmd_valid = (state != IDLE) && (state != DONE) && !issued && !eng_busy;

    always_comb
    begin
        cmd = '{op: OP_STOP, tx_byte: 8'h00, master_ack: 1'b0};
        case (state)
            START, RESTART:
                cmd.op = OP_START;
            CTRL_WRITE:
            begin
                cmd.op      = OP_WRITE_BYTE;
                cmd.tx_byte = {`EE_DEVICE_CODE, req_q.addr[10:8], 1'b0};
            end
            ADDR_WRITE:
            begin
                cmd.op      = OP_WRITE_BYTE;
                cmd.tx_byte = req_q.addr[7:0];
            end
            DATA_WRITE:
            begin
                cmd.op      = OP_WRITE_BYTE;
                cmd.tx_byte = req_q.wdata;
            end
            CTRL_READ:
            begin
                cmd.op      = OP_WRITE_BYTE;
                cmd.tx_byte = {`EE_DEVICE_CODE, req_q.addr[10:8], 1'b1};
            end
            DATA_READ:
            begin
                cmd.op         = OP_READ_BYTE;
                cmd.master_ack = 1'b1;  // single byte, nack then stop
            end
            default:
                cmd.op = OP_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            issued    <= 1'b0;
            ack       <= 1'b0;
            rd_q      <= 1'b0;
            nack_seen <= 1'b0;
        end
        else
        begin
            ack <= 1'b0;
            if (cmd_valid)
                issued <= 1'b1;
            if (op_done)
            begin
                issued    <= 1'b0;
                nack_seen <= nack_seen | rsp.slave_nack;
            end
            case (state)
                IDLE:
                begin
                    if (wr || rd)
                    begin
                        rd_q      <= !wr;  // wr wins
                        nack_seen <= 1'b0;
                        state     <= START;
                    end
                end
                START:
                    if (op_done) state <= CTRL_WRITE;
                CTRL_WRITE:
                    if (op_done) state <= ADDR_WRITE;
                ADDR_WRITE:
                    if (op_done) state <= rd_q ? RESTART : DATA_WRITE;
                DATA_WRITE:
                    if (op_done) state <= STOP;
                RESTART:
                    if (op_done) state <= CTRL_READ;
                CTRL_READ:
                    if (op_done) state <= DATA_READ;
                DATA_READ:
                    if (op_done) state <= STOP;
                STOP:
                    if (op_done) state <= DONE;
                default:
                begin
                    ack   <= 1'b1;
                    state <= IDLE;
                end
            endcase
        end
    end

    // request payload and read data
    always_ff @(posedge CLK)
    begin
        if (state == IDLE && (wr || rd))
            req_q <= req;
        if (state == DATA_READ && op_done)
            rdata <= rsp.rx_byte;
    end

endmodule

// ==== source/eeprom_controller.sv ====
`timescale 1ns/1ps

module eeprom_controller
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       wr,
    input  logic       rd,
    input  host_req_t  req,
    output logic       busy,
    output logic       ack,
    output logic [7:0] rdata,
    output logic       nack_seen,
    output logic       scl,
    output logic       sda_drive_low,
    input  logic       sda_in
);

    bus_cmd_t cmd;
    bus_rsp_t rsp;
    logic     cmd_valid;
    logic     eng_busy;
    logic     op_done;

    eeprom_access_fsm u_fsm (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .req       (req),
        .busy      (busy),
        .ack       (ack),
        .rdata     (rdata),
        .nack_seen (nack_seen),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .eng_busy  (eng_busy),
        .op_done   (op_done),
        .rsp       (rsp)
    );

    // open-drain sda, scl push-pull
    i2c_bit_engine u_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .eng_busy      (eng_busy),
        .op_done       (op_done),
        .rsp           (rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

// ==== source/eeprom_defs.svh ====
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// CLK cycles per quarter of an SCL period, one bit is four quarters
`define EE_QUARTER 2

// control byte prefix of a 24C16 type part
`define EE_DEVICE_CODE 4'b1010

`endif

// ==== source/eeprom_pkg.sv ====
package eeprom_pkg;

    // single bus operation carried out by the engine
    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE_BYTE,
        OP_READ_BYTE
    } bus_op_t;

    typedef struct packed {
        bus_op_t    op;
        logic [7:0] tx_byte;
        logic       master_ack;  // level driven in 9th bit of a read, 1 = nack
    } bus_cmd_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       slave_nack;
    } bus_rsp_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WRITE,
        ADDR_WRITE,
        DATA_WRITE,
        RESTART,
        CTRL_READ,
        DATA_READ,
        STOP,
        DONE
    } access_state_t;

    typedef struct packed {
        logic [10:0] addr;
        logic [7:0]  wdata;
    } host_req_t;

endpackage

// ==== source/i2c_bit_engine.sv ====
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     cmd_valid,
    input  bus_cmd_t cmd,
    output logic     eng_busy,
    output logic     op_done,
    output bus_rsp_t rsp,
    output logic     scl,
    output logic     sda_drive_low,
    input  logic     sda_in
);

    localparam int QW = ($clog2(`EE_QUARTER) > 0) ? $clog2(`EE_QUARTER) : 1;

    bus_op_t       op_q;
    logic          mack_q;
    logic [QW-1:0] q_cnt;
    logic [1:0]    phase;    // 0 low, 1/2 high, 3 low for data bits
    logic [3:0]    bit_cnt;  // 0..7 data, 8 = ack slot
    logic [7:0]    sh;
    logic [7:0]    rx;
    logic          nack;

    logic          q_end;
    logic          last;
    logic [1:0]    phase_n;
    logic [3:0]    bit_n;
    logic [7:0]    sh_n;

    // {scl, drive_low} for a given point of an operation
    function automatic logic [1:0] bus_level(input bus_op_t op, input logic [1:0] ph,
                                             input logic [3:0] b, input logic bit7,
                                             input logic mack);
        logic scl_l;
        logic low_l;
        scl_l = (ph == 2'd1) || (ph == 2'd2);
        low_l = 1'b0;
        case (op)
            OP_START:      low_l = ph[1];            // falls while scl high
            OP_STOP:
            begin
                scl_l = (ph != 2'd0);
                low_l = !ph[1];                      // rises while scl high
            end
            OP_WRITE_BYTE: low_l = (b < 4'd8) && !bit7;
            default:       low_l = (b == 4'd8) && !mack;
        endcase
        return {scl_l, low_l};
    endfunction

    assign q_end = (q_cnt == QW'(`EE_QUARTER - 1));
    assign last  = q_end && (phase == 2'd3) &&
                   ((op_q == OP_START) || (op_q == OP_STOP) || (bit_cnt == 4'd8));

    always_comb
    begin
        phase_n = phase + 2'd1;
        bit_n   = bit_cnt;
        sh_n    = sh;
        if (phase == 2'd3)
        begin
            bit_n = bit_cnt + 4'd1;
            sh_n  = {sh[6:0], 1'b0};
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            eng_busy      <= 1'b0;
            op_done       <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            q_cnt         <= '0;
            phase         <= 2'd0;
            bit_cnt       <= 4'd0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!eng_busy)
            begin
                if (cmd_valid)
                begin
                    eng_busy <= 1'b1;
                    q_cnt    <= '0;
                    phase    <= 2'd0;
                    bit_cnt  <= 4'd0;
                    {scl, sda_drive_low} <= bus_level(cmd.op, 2'd0, 4'd0,
                                                      cmd.tx_byte[7], cmd.master_ack);
                end
            end
            else
            begin
                q_cnt <= q_end ? '0 : q_cnt + 1'b1;
                if (last)
                begin
                    eng_busy <= 1'b0;
                    op_done  <= 1'b1;  // levels hold until the next op
                end
                else if (q_end)
                begin
                    phase   <= phase_n;
                    bit_cnt <= bit_n;
                    {scl, sda_drive_low} <= bus_level(op_q, phase_n, bit_n, sh_n[7], mack_q);
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!eng_busy && cmd_valid)
        begin
            op_q   <= cmd.op;
            mack_q <= cmd.master_ack;
            sh     <= cmd.tx_byte;
            nack   <= 1'b0;
        end
        else if (eng_busy && q_end)
        begin
            if (phase == 2'd3)
                sh <= sh_n;
            // sample in the middle of scl high
            if (phase == 2'd1 && (op_q == OP_WRITE_BYTE || op_q == OP_READ_BYTE))
            begin
                if (bit_cnt < 4'd8)
                    rx <= {rx[6:0], sda_in};
                else if (op_q == OP_WRITE_BYTE)
                    nack <= sda_in;
            end
        end
    end

    assign rsp = '{rx_byte: rx, slave_nack: nack};

endmodule

// ==== testbench/eeprom_model.sv ====
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_model
(
    input  logic        scl,
    input  logic        sda,
    input  logic        withhold,   // nack control bytes while high
    output logic        sda_rel,    // 0 pulls the line low
    output logic [10:0] dec_addr,
    output logic        bad_code
);

    logic [7:0]  mem [0:2047];
    logic [7:0]  shreg = 8'h00;
    logic [7:0]  tx = 8'h00;
    logic [3:0]  bit_i = 4'd0;      // 8 is the ack slot
    logic [1:0]  byte_cnt = 2'd0;
    logic [2:0]  blk = 3'd0;
    logic [10:0] ptr = 11'd0;
    logic        rel = 1'b1;
    logic        code_err = 1'b0;
    logic        active = 1'b0;
    logic        skip_fall = 1'b0;  // scl fall that ends a start
    logic        rd_dir = 1'b0;
    logic        drop = 1'b0;
    logic        m_nack = 1'b0;
    logic        scl_q = 1'b1;
    logic        sda_q = 1'b1;

    assign sda_rel  = rel;
    assign dec_addr = ptr;
    assign bad_code = code_err;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i[10:0]] = i[7:0] ^ {1'b0, i[10:8], 4'b0000};
    end

    task take_byte();
        if (byte_cnt == 2'd0)
        begin
            if (shreg[7:4] != `EE_DEVICE_CODE)
                code_err = 1'b1;
            blk    = shreg[3:1];
            rd_dir = shreg[0];
            drop   = withhold;
        end
        else if (byte_cnt == 2'd1)
            ptr = {blk, shreg};  // block bits from the control byte
        else
            mem[ptr] = shreg;
    endtask

    task scl_rise();
        if (bit_i < 4'd8 && !rd_dir)
            shreg = {shreg[6:0], sda};
        else if (bit_i == 4'd8 && rd_dir)
            m_nack = sda;
    endtask

    task scl_fall();
        if (skip_fall)
            skip_fall = 1'b0;
        else if (bit_i == 4'd8)
        begin
            bit_i    = 4'd0;
            byte_cnt = byte_cnt + 2'd1;
            if (drop || (rd_dir && m_nack))
            begin
                active = 1'b0;
                rel    = 1'b1;
            end
            else if (rd_dir)
            begin
                tx  = mem[ptr];
                rel = tx[7];
            end
            else
                rel = 1'b1;
        end
        else
        begin
            if (bit_i == 4'd7 && !rd_dir)
            begin
                take_byte();
                rel = drop;         // ack unless withheld
            end
            else if (bit_i == 4'd7)
                rel = 1'b1;         // master owns the ack slot
            else if (rd_dir)
                rel = tx[3'd6 - bit_i[2:0]];
            bit_i = bit_i + 4'd1;
        end
    endtask

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
        begin
            if (sda === 1'b0)
            begin
                active    = 1'b1;   // start or repeated start
                skip_fall = 1'b1;
                bit_i     = 4'd0;
                byte_cnt  = 2'd0;
                rd_dir    = 1'b0;
                drop      = 1'b0;
                m_nack    = 1'b0;
                rel       = 1'b1;
            end
            else
            begin
                active = 1'b0;      // stop
                rel    = 1'b1;
            end
        end
        else if (active && scl === 1'b1 && scl_q !== 1'b1)
            scl_rise();
        else if (active && scl === 1'b0 && scl_q === 1'b1)
            scl_fall();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== testbench/eeprom_tb.sv ====
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_tb
    import eeprom_pkg::*;
();

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    host_req_t   req;
    logic        busy;
    logic        ack;
    logic [7:0]  rdata;
    logic        nack_seen;
    logic        scl;
    logic        sda_drive_low;
    logic        sda;
    logic        sda_rel;
    logic        withhold;
    logic        bad_code;
    logic [10:0] dec_addr;

    logic [7:0]  ref_mem [0:2047];
    logic [15:0] lfsr = 16'd41;
    int          acks_seen;
    int          acks_expected;

    assign sda = !sda_drive_low && sda_rel;  // wired-AND of both sides

    eeprom_controller uut (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .req           (req),
        .busy          (busy),
        .ack           (ack),
        .rdata         (rdata),
        .nack_seen     (nack_seen),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)
    );

    eeprom_model slave (
        .scl      (scl),
        .sda      (sda),
        .withhold (withhold),
        .sda_rel  (sda_rel),
        .dec_addr (dec_addr),
        .bad_code (bad_code)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                               $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                               $time, what, got, exp));
    endtask

    task automatic check_addr(input logic [10:0] got, input logic [10:0] exp,
                              input string what);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                               $time, what, got, exp));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] fill_value(input logic [10:0] a);
        return a[7:0] ^ {1'b0, a[10:8], 4'b0000};  // low byte xor block * 16
    endfunction

    task automatic pulse_strobe(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
        @(posedge CLK);
        #1;
        wr  = is_wr;
        rd  = !is_wr;
        req = '{addr: a, wdata: d};
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack();
        @(posedge CLK);
        #1;
        while (!ack)
        begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic access(input logic is_wr, input logic [10:0] a, input logic [7:0] d,
                          input logic nack_exp);
        pulse_strobe(is_wr, a, d);
        wait_ack();
        acks_expected++;
        check_flag(nack_seen, nack_exp, "nack_seen");
        if (!nack_exp)
        begin
            check_addr(dec_addr, a, "decoded address");
            if (is_wr)
                ref_mem[a] = d;
            else
                check_byte(rdata, ref_mem[a], "rdata");
        end
    endtask

    // extra strobes during a write must be dropped
    task automatic strobe_while_busy(input logic [10:0] a, input logic [7:0] d);
        pulse_strobe(1'b1, a, d);
        repeat (4) @(posedge CLK);
        #1;
        if (busy !== 1'b1)
            fail_run("busy was low while a write was in progress");
        pulse_strobe(1'b1, a, ~d);
        pulse_strobe(1'b0, a, ~d);
        wait_ack();
        acks_expected++;
        check_flag(nack_seen, 1'b0, "nack_seen");
        ref_mem[a] = d;
        repeat (40) @(posedge CLK);
        #1;
        if (busy !== 1'b0 || acks_seen != acks_expected)
            fail_run("a strobe issued while busy started another access");
    endtask

    always @(negedge CLK)
        if (ack === 1'b1)
            acks_seen++;

    always @(posedge bad_code)
        fail_run("the slave saw a control byte whose device code is not 1010");

    // 200 accesses of 400 quarter periods each
    initial
    begin
        repeat (200 * 400 * `EE_QUARTER) @(posedge CLK);
        fail_run("the run timed out before all accesses completed");
    end

    initial
    begin
        logic [31:0] v;
        logic [10:0] a;
        logic [10:0] last_a;
        logic [7:0]  d;
        logic        is_wr;

        RESET    = 1'b1;
        wr       = 1'b0;
        rd       = 1'b0;
        req      = '0;
        withhold = 1'b0;
        last_a   = 11'h000;
        for (int i = 0; i < 2048; i++)
            ref_mem[i[10:0]] = fill_value(i[10:0]);

        repeat (3) @(posedge CLK);
        #1;
        RESET = 1'b0;
        check_flag(scl, 1'b1, "scl after reset");
        check_flag(sda_drive_low, 1'b0, "sda_drive_low after reset");
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(ack, 1'b0, "ack after reset");

        access(1'b1, 11'h5a3, 8'h3c, 1'b0);
        access(1'b0, 11'h5a3, 8'h00, 1'b0);

        for (int n = 0; n < 150; n++)
        begin
            take_bits(1, v);
            is_wr = v[0];
            take_bits(1, v);
            if (v[0])
                a = last_a;  // revisit the previous address
            else
            begin
                take_bits(11, v);
                a = v[10:0];
            end
            take_bits(8, v);
            d = v[7:0];
            access(is_wr, a, d, 1'b0);
            last_a = a;
        end

        strobe_while_busy(11'h7ff, 8'h96);
        access(1'b0, 11'h7ff, 8'h00, 1'b0);

        // write with the ack withheld must not land
        withhold = 1'b1;
        access(1'b1, 11'h123, 8'hee, 1'b1);
        withhold = 1'b0;
        access(1'b0, 11'h123, 8'h00, 1'b0);

        repeat (2) @(posedge CLK);
        if (acks_seen != acks_expected)
            fail_run("the number of ack pulses differs from the number of accesses");
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule
